//--- alu.sv
`timescale 1ns/1ns

module alu
    import cpu_pkg::*;
(
    input  opcode_t opcode,
    input  word_t   reg_a,
    input  word_t   reg_b,
    input  word_t   data,
    input  imm_t    value,
    input  logic    highlow,
    input  logic    flag_a,
    input  logic    flag_b,
    output word_t   result,
    output logic    flag_out,
    output logic    reg_write,
    output logic    jump,
    output addr_t   jump_addr
);

    logic [WORD_W:0] sum;
    word_t           diff;
    word_t           imm_ext;
    logic            less;
    logic            equal;

    assign sum     = {1'b0, reg_a} + {1'b0, reg_b};
    assign diff    = reg_a - reg_b;
    assign imm_ext = word_t'(value);
    assign less    = reg_a < reg_b;
    assign equal   = reg_a == reg_b;

    // result and flag per opcode
    always_comb
    begin
        result    = '0;
        flag_out  = 1'b0;
        reg_write = 1'b0;
        case (opcode)
            OP_LI:
            begin
                // high half keeps the low half of source a
                if (highlow)
                    result = {value, reg_a[IMM_W-1:0]};
                else
                    result = imm_ext;
                flag_out  = result == '0;
                reg_write = 1'b1;
            end
            OP_ADD:
            begin
                result    = sum[WORD_W-1:0];
                flag_out  = sum[WORD_W];
                reg_write = 1'b1;
            end
            OP_SUB:
            begin
                // borrow out
                result    = diff;
                flag_out  = less;
                reg_write = 1'b1;
            end
            OP_AND:
            begin
                result    = reg_a & reg_b;
                flag_out  = result == '0;
                reg_write = 1'b1;
            end
            OP_OR:
            begin
                result    = reg_a | reg_b;
                flag_out  = result == '0;
                reg_write = 1'b1;
            end
            OP_XOR:
            begin
                result    = reg_a ^ reg_b;
                flag_out  = result == '0;
                reg_write = 1'b1;
            end
            OP_SLT:
            begin
                // equal operands count as less when flag b is set
                result    = word_t'(less);
                flag_out  = less | (equal & flag_b);
                reg_write = 1'b1;
            end
            OP_LD:
            begin
                result    = data;
                flag_out  = data == '0;
                reg_write = 1'b1;
            end
            default:
            begin
                reg_write = 1'b0;
            end
        endcase
    end

    assign jump      = (opcode == OP_JMP) | ((opcode == OP_BRF) & flag_a);
    assign jump_addr = addr_t'(value);

endmodule

//--- cpu.sv
`timescale 1ns/1ns

module cpu
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = '0
)
(
    input  logic  clear,
    input  logic  reset,
    input  word_t data,
    output word_t datao,
    output addr_t address,
    output logic  rw
);

    seq_state_t state;
    opcode_t    opcode;
    rsel_t      sel_a;
    rsel_t      sel_b;
    rsel_t      sel_d;
    logic       highlow;
    imm_t       value;
    logic       write_en;
    word_t      reg_a;
    word_t      reg_b;
    logic       flag_a;
    logic       flag_b;
    word_t      result;
    logic       flag_out;
    logic       reg_write;
    logic       jump;
    addr_t      jump_addr;

    sequencer u_sequencer (
        .clear     (clear),
        .reset     (reset),
        .data      (data),
        .reg_write (reg_write),
        .reg_a     (reg_a),
        .state     (state),
        .opcode    (opcode),
        .sel_a     (sel_a),
        .sel_b     (sel_b),
        .sel_d     (sel_d),
        .highlow   (highlow),
        .value     (value),
        .write_en  (write_en),
        .rw        (rw),
        .datao     (datao)
    );

    register_file u_register_file (
        .clear    (clear),
        .reset    (reset),
        .write_en (write_en),
        .sel_d    (sel_d),
        .result   (result),
        .flag_out (flag_out),
        .sel_a    (sel_a),
        .sel_b    (sel_b),
        .reg_a    (reg_a),
        .reg_b    (reg_b),
        .flag_a   (flag_a),
        .flag_b   (flag_b)
    );

    alu u_alu (
        .opcode    (opcode),
        .reg_a     (reg_a),
        .reg_b     (reg_b),
        .data      (data),
        .value     (value),
        .highlow   (highlow),
        .flag_a    (flag_a),
        .flag_b    (flag_b),
        .result    (result),
        .flag_out  (flag_out),
        .reg_write (reg_write),
        .jump      (jump),
        .jump_addr (jump_addr)
    );

    program_counter #(
        .RESET_PC (RESET_PC)
    ) u_program_counter (
        .clear     (clear),
        .reset     (reset),
        .state     (state),
        .opcode    (opcode),
        .value     (value),
        .jump      (jump),
        .jump_addr (jump_addr),
        .address   (address)
    );

endmodule

//--- cpu_asserts.sv
`timescale 1ns/1ns

module cpu_asserts
    import cpu_pkg::*;
(
    input logic       clear,
    input logic       reset,
    input seq_state_t state,
    input logic       rw,
    input logic       write_en
);

    // only the three sequencer states ever appear
    state_legal: assert property (@(posedge clear) disable iff (reset)
        state inside {FETCH, EXECUTE, ADVANCE})
        else $error("sequencer state outside its legal values");

    // every fetch runs through execute and advance
    state_order: assert property (@(posedge clear) disable iff (reset)
        state == FETCH |=> state == EXECUTE ##1 state == ADVANCE)
        else $error("sequencer did not step fetch, execute, advance");

    // the bus writes only while executing
    store_in_execute: assert property (@(posedge clear) disable iff (reset)
        !rw |-> state == EXECUTE)
        else $error("rw low outside execute");

    write_in_execute: assert property (@(posedge clear) disable iff (reset)
        write_en |-> state == EXECUTE)
        else $error("register write enable high outside execute");

endmodule

//--- cpu_pkg.sv
package cpu_pkg;

    // widths with a meaning in the instruction set
    localparam int WORD_W   = 32;
    localparam int ADDR_W   = 32;
    localparam int RSEL_W   = 3;
    localparam int OP_W     = 6;
    localparam int IMM_W    = 16;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [RSEL_W-1:0] rsel_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [IMM_W-1:0]  imm_t;

    // instruction opcodes, bits 5..0 of the instruction word
    localparam opcode_t OP_NOP = 6'd0;
    localparam opcode_t OP_LI  = 6'd1;
    localparam opcode_t OP_ADD = 6'd2;
    localparam opcode_t OP_SUB = 6'd3;
    localparam opcode_t OP_AND = 6'd4;
    localparam opcode_t OP_OR  = 6'd5;
    localparam opcode_t OP_XOR = 6'd6;
    localparam opcode_t OP_ST  = 6'd7;
    localparam opcode_t OP_SLT = 6'd8;
    localparam opcode_t OP_LD  = 6'd9;
    localparam opcode_t OP_JMP = 6'd10;
    localparam opcode_t OP_BRF = 6'd11;

    // instruction field positions
    localparam int OPC_LSB = 0;
    localparam int SELA_LSB = 6;
    localparam int SELB_LSB = 9;
    localparam int SELD_LSB = 12;
    localparam int HL_BIT = 15;
    localparam int IMM_LSB = 16;

    // three steps per instruction
    typedef enum logic [1:0] {
        FETCH,
        EXECUTE,
        ADVANCE
    } seq_state_t;

endpackage

//--- files.f
cpu_pkg.sv
register_file.sv
alu.sv
sequencer.sv
program_counter.sv
cpu.sv
cpu_asserts.sv
tb_cpu.sv

//--- program_counter.sv
`timescale 1ns/1ns

module program_counter
    import cpu_pkg::*;
#(
    parameter addr_t RESET_PC = '0
)
(
    input  logic       clear,
    input  logic       reset,
    input  seq_state_t state,
    input  opcode_t    opcode,
    input  imm_t       value,
    input  logic       jump,
    input  addr_t      jump_addr,
    output addr_t      address
);

    addr_t pc;
    addr_t pc_next;
    logic  data_access;

    assign pc_next = jump ? jump_addr : pc + addr_t'(1);

    always_ff @(posedge clear)
    begin
        if (reset)
            pc <= RESET_PC;
        else if (state == ADVANCE)
            pc <= pc_next;
    end

    // loads and stores take the port during execute
    assign data_access = (state == EXECUTE) & ((opcode == OP_LD) | (opcode == OP_ST));
    assign address     = data_access ? addr_t'(value) : pc;

endmodule

//--- register_file.sv
`timescale 1ns/1ns

module register_file
    import cpu_pkg::*;
(
    input  logic  clear,
    input  logic  reset,
    input  logic  write_en,
    input  rsel_t sel_d,
    input  word_t result,
    input  logic  flag_out,
    input  rsel_t sel_a,
    input  rsel_t sel_b,
    output word_t reg_a,
    output word_t reg_b,
    output logic  flag_a,
    output logic  flag_b
);

    word_t                regs [NUM_REGS];
    logic  [NUM_REGS-1:0] flags;

    // one write port, register and its flag written together
    always_ff @(posedge clear)
    begin
        if (reset)
        begin
            for (int i = 0; i < NUM_REGS; i++)
            begin
                regs[i] <= '0;
            end
            flags <= '0;
        end
        else if (write_en)
        begin
            regs[sel_d]  <= result;
            flags[sel_d] <= flag_out;
        end
    end

    // combinational reads
    always_comb
    begin
        reg_a = regs[sel_a];
        reg_b = regs[sel_b];
    end

    // flag reads follow the register selects
    always_comb
    begin
        flag_a = flags[sel_a];
        flag_b = flags[sel_b];
    end

endmodule

//--- sequencer.sv
`timescale 1ns/1ns

module sequencer
    import cpu_pkg::*;
(
    input  logic       clear,
    input  logic       reset,
    input  word_t      data,
    input  logic       reg_write,
    input  word_t      reg_a,
    output seq_state_t state,
    output opcode_t    opcode,
    output rsel_t      sel_a,
    output rsel_t      sel_b,
    output rsel_t      sel_d,
    output logic       highlow,
    output imm_t       value,
    output logic       write_en,
    output logic       rw,
    output word_t      datao
);

    seq_state_t state_next;
    word_t      instr;

    // fetch, execute, advance, repeat
    always_comb
    begin
        case (state)
            FETCH:   state_next = EXECUTE;
            EXECUTE: state_next = ADVANCE;
            ADVANCE: state_next = FETCH;
            default: state_next = FETCH;
        endcase
    end

    always_ff @(posedge clear)
    begin
        if (reset)
            state <= FETCH;
        else
            state <= state_next;
    end

    // instruction register loads from the memory port while fetching
    always_ff @(posedge clear)
    begin
        if (reset)
            instr <= '0;
        else if (state == FETCH)
            instr <= data;
    end

    // field decode
    assign opcode  = instr[OPC_LSB +: OP_W];
    assign sel_a   = instr[SELA_LSB +: RSEL_W];
    assign sel_b   = instr[SELB_LSB +: RSEL_W];
    assign sel_d   = instr[SELD_LSB +: RSEL_W];
    assign highlow = instr[HL_BIT];
    assign value   = instr[IMM_LSB +: IMM_W];

    // register write lands on the edge that ends execute
    assign write_en = reg_write & (state == EXECUTE);

    // rw is a read level except for the execute cycle of a store
    assign rw    = ~((state == EXECUTE) & (opcode == OP_ST));
    assign datao = reg_a;

endmodule

//--- tb_cpu.sv
`timescale 1ns/1ns

module tb_cpu
    import cpu_pkg::*;
();

    logic  clear;
    logic  reset;
    word_t data;
    word_t datao;
    addr_t address;
    logic  rw;

    word_t mem [256];
    addr_t log_addr [$];
    word_t log_data [$];
    word_t rng_state = 32'he98c;
    int    checks = 0;
    int    errors = 0;
    int    prog_len;

    cpu #(.RESET_PC('0)) dut (
        .clear   (clear),
        .reset   (reset),
        .data    (data),
        .datao   (datao),
        .address (address),
        .rw      (rw)
    );

    bind sequencer cpu_asserts u_cpu_asserts (
        .clear    (clear),
        .reset    (reset),
        .state    (state),
        .rw       (rw),
        .write_en (write_en)
    );

    initial
    begin
        clear = 1'b0;
        forever #2 clear = ~clear;
    end

    // memory answers within the cycle
    assign data = mem[address[7:0]];

    // every store is logged and written to memory
    always @(posedge clear)
    begin
        if (!reset && !rw)
        begin
            log_addr.push_back(address);
            log_data.push_back(datao);
            mem[address[7:0]] = datao;
        end
    end

    function automatic word_t next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic word_t encode(opcode_t op, rsel_t a, rsel_t b, rsel_t d, logic hl,
                                     imm_t imm);
        return {imm, hl, d, b, a, op};
    endfunction

    // expected result of a register to register operation
    function automatic word_t model_op(opcode_t op, word_t a, word_t b);
        case (op)
            OP_ADD: return a + b;
            OP_SUB: return a - b;
            OP_AND: return a & b;
            OP_OR:  return a | b;
            OP_XOR: return a ^ b;
            OP_SLT: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %0t ns %s: got %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input int exp);
        checks++;
        if (log_addr.size() != exp)
        begin
            errors++;
            $display("[FAIL] %0t ns store count: got %0d, expected %0d", $time,
                     log_addr.size(), exp);
        end
    endtask

    task automatic check_store(input int idx, input addr_t exp_addr, input word_t exp_data);
        if (idx >= log_addr.size())
        begin
            errors++;
            $display("store %0d is missing from the store log at %0t ns", idx, $time);
        end
        else
        begin
            check_addr($sformatf("store %0d address", idx), log_addr[idx], exp_addr);
            check_word($sformatf("store %0d datao", idx), log_data[idx], exp_data);
        end
    endtask

    task automatic clear_memory();
        for (int i = 0; i < 256; i++)
        begin
            // low half is NOP program space, only the opcode field is clear
            if (i < 128)
                mem[i] = {~8'(i), 8'(i), 10'(i), OP_NOP};
            else
                mem[i] = {8'hc3, 8'(i), ~8'(i), 8'(i)};
        end
        prog_len = 0;
    endtask

    task automatic emit(input word_t instr);
        mem[prog_len] = instr;
        prog_len++;
    endtask

    task automatic load_register(input rsel_t r, input word_t v);
        emit(encode(OP_LI, 3'd0, 3'd0, r, 1'b0, v[15:0]));
        emit(encode(OP_LI, r, 3'd0, r, 1'b1, v[31:16]));
    endtask

    task automatic hold_reset();
        @(negedge clear);
        reset = 1'b1;
    endtask

    task automatic release_reset();
        repeat (5) @(negedge clear);
        reset = 1'b0;
        log_addr.delete();
        log_data.delete();
    endtask

    task automatic wait_for_address(input addr_t target, input int limit);
        int n;
        n = 0;
        while (address !== target && n < limit)
        begin
            @(negedge clear);
            n++;
        end
        if (address !== target)
        begin
            errors++;
            $display("timeout at %0t ns: fetch never reached address 0x%0h", $time, target);
        end
    endtask

    // append a jump to itself, run until it is fetched
    task automatic run_program();
        addr_t halt;
        halt = addr_t'(prog_len);
        emit(encode(OP_JMP, 3'd0, 3'd0, 3'd0, 1'b0, imm_t'(prog_len)));
        release_reset();
        wait_for_address(halt, 3 * prog_len + 10);
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("test %s finished with %0d errors", name, errors - errors_before);
    endtask

    task automatic test_reset_cadence();
        int e0;
        e0 = errors;
        hold_reset();
        clear_memory();
        release_reset();
        for (int k = 0; k < 9; k++)
        begin
            check_addr("address", address, addr_t'(k / 3));
            check_bit("rw", rw, 1'b1);
            @(negedge clear);
        end
        report_test("reset and fetch cadence", e0);
    endtask

    task automatic test_immediates();
        int   e0;
        imm_t lo;
        imm_t hi;
        e0 = errors;
        lo = imm_t'(next_random());
        hi = imm_t'(next_random());
        hold_reset();
        clear_memory();
        emit(encode(OP_LI, 3'd0, 3'd0, 3'd1, 1'b0, lo));
        emit(encode(OP_LI, 3'd1, 3'd0, 3'd1, 1'b1, hi));
        emit(encode(OP_ST, 3'd1, 3'd0, 3'd0, 1'b0, 16'h0080));
        run_program();
        check_count(1);
        check_store(0, 32'h80, {hi, lo});
        report_test("immediates and store", e0);
    endtask

    task automatic test_arith_logic();
        int      e0;
        word_t   a;
        word_t   b;
        opcode_t ops [6];
        e0 = errors;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
        a = next_random();
        b = next_random();
        hold_reset();
        clear_memory();
        load_register(3'd1, a);
        load_register(3'd2, b);
        for (int k = 0; k < 6; k++)
        begin
            emit(encode(ops[k], 3'd1, 3'd2, 3'd3, 1'b0, 16'h0000));
            emit(encode(OP_ST, 3'd3, 3'd0, 3'd0, 1'b0, imm_t'(16'h90 + k)));
        end
        run_program();
        check_count(6);
        for (int k = 0; k < 6; k++)
        begin
            check_store(k, addr_t'(32'h90 + k), model_op(ops[k], a, b));
        end
        report_test("arithmetic and logic", e0);
    endtask

    task automatic test_flags_branches();
        int e0;
        e0 = errors;
        hold_reset();
        clear_memory();
        emit(encode(OP_LI, 3'd0, 3'd0, 3'd1, 1'b0, 16'd5));
        emit(encode(OP_LI, 3'd0, 3'd0, 3'd2, 1'b0, 16'd9));
        // 5 - 9 borrows, so the branch at 3 skips the store at 4
        emit(encode(OP_SUB, 3'd1, 3'd2, 3'd3, 1'b0, 16'd0));
        emit(encode(OP_BRF, 3'd3, 3'd0, 3'd0, 1'b0, 16'd5));
        emit(encode(OP_ST, 3'd1, 3'd0, 3'd0, 1'b0, 16'h00a0));
        // 9 - 5 does not borrow, store at 7 happens
        emit(encode(OP_SUB, 3'd2, 3'd1, 3'd4, 1'b0, 16'd0));
        emit(encode(OP_BRF, 3'd4, 3'd0, 3'd0, 1'b0, 16'd8));
        emit(encode(OP_ST, 3'd2, 3'd0, 3'd0, 1'b0, 16'h00a1));
        emit(encode(OP_JMP, 3'd0, 3'd0, 3'd0, 1'b0, 16'd10));
        emit(encode(OP_ST, 3'd1, 3'd0, 3'd0, 1'b0, 16'h00a2));
        emit(encode(OP_ST, 3'd3, 3'd0, 3'd0, 1'b0, 16'h00a3));
        run_program();
        check_count(2);
        check_store(0, 32'ha1, 32'd9);
        check_store(1, 32'ha3, word_t'(5) - word_t'(9));
        report_test("flags and branches", e0);
    endtask

    task automatic test_load();
        int    e0;
        word_t w;
        e0 = errors;
        w = next_random();
        hold_reset();
        clear_memory();
        mem[8'hb0] = w;
        emit(encode(OP_LD, 3'd0, 3'd0, 3'd5, 1'b0, 16'h00b0));
        emit(encode(OP_ST, 3'd5, 3'd0, 3'd0, 1'b0, 16'h00b1));
        run_program();
        check_count(1);
        check_store(0, 32'hb1, w);
        report_test("load", e0);
    endtask

    initial
    begin
        reset = 1'b1;
        clear_memory();
        test_reset_cadence();
        test_immediates();
        test_arith_logic();
        test_flags_branches();
        test_load();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
